/* tsMemMap.f */
rtl/tsMemPkg.sv
rtl/tsLoadPkg.sv
rtl/byteBank.sv
rtl/mapDecoder.sv
rtl/readSelect.sv
rtl/tsMemMap.sv
tb/tsMemMapTb.sv

/* Makefile */
# Verilator build and run of the memory map testbench

TOP = tsMemMapTb
SIM = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): tsMemMap.f $(wildcard rtl/*.sv) $(wildcard tb/*.sv)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f tsMemMap.f

# the run passes only if the pass line shows up
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* tb/tsMemMapTb.sv */
// testbench for the memory map with clock, reset, stimulus, reference model, assertions and reports
`timescale 1ns/1ps
`default_nettype none

module tsMemMapTb;

	// loader bytes of all images plus the late dock bytes
	localparam int LoadCycles = 16384 + 8192 + 8192 + 5 * 8192 + 64;
	// cpu accesses and map changes of all tests rounded up
	localparam int AccessCycles = 4000;
	localparam int CycleLimit = LoadCycles + 2 * AccessCycles + 1000;

	logic clock;
	logic rstN;
	logic reqValid;
	logic reqReady;
	logic reqWrite;
	logic [tsMemPkg::CpuAddrWidth-1:0] reqAddr;
	logic [tsMemPkg::ByteWidth-1:0] reqData;
	logic mapped;
	logic ramcs;
	logic [tsMemPkg::PageWidth-1:0] page;
	logic [tsMemPkg::ChunkCount-1:0] memM;
	logic memB;
	logic rspValid;
	logic [tsMemPkg::ByteWidth-1:0] rspData;
	logic loadValid;
	tsLoadPkg::LoadIndex loadIndex;
	logic [tsLoadPkg::LoadAddrWidth-1:0] loadAddr;
	logic [tsMemPkg::ByteWidth-1:0] loadData;

	// shadow stores of the reference model
	logic [7:0] homeMem [16384];
	logic [7:0] extMem [8192];
	logic [7:0] dockMem [65536];
	logic [7:0] esxMem [8192];
	logic [7:0] divMem [131072];
	logic [2:0] dockTop = 3'd0;
	logic [7:0] expByte = 8'h00;
	logic readPending = 1'b0;
	logic readGo;
	logic [31:0] rngState = 32'd8354;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int testCount = 0;
	int testErrorBase = 0;

	tsMemMap i_dut (
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.mapped(mapped),
		.ramcs(ramcs),
		.page(page),
		.memM(memM),
		.memB(memB),
		.rspValid(rspValid),
		.rspData(rspData),
		.loadValid(loadValid),
		.loadIndex(loadIndex),
		.loadAddr(loadAddr),
		.loadData(loadData)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ============================================================
	// reference model
	// ============================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] randomWord();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// expected byte for a read under the current map controls
	function automatic logic [7:0] modelRead(input logic [15:0] addr);
		logic [2:0] chunk;
		chunk = addr[15:13];
		// overlay on the lower 16K wins over everything
		if (mapped && addr[15:14] == 2'b00) begin
			return ramcs ? divMem[{page, addr[12:0]}] : esxMem[addr[12:0]];
		end
		if (memM[chunk]) begin
			if (memB) begin
				return (chunk == 3'd0) ? extMem[addr[12:0]] : 8'hFF;
			end
			return (chunk <= dockTop) ? dockMem[addr] : 8'hFF;
		end
		// home rom mirrors every 16K
		return homeMem[addr[13:0]];
	endfunction

	assign readGo = reqValid && reqReady && !reqWrite;

	// model follows the same edges as the DUT
	always @(posedge clock) begin
		readPending <= readGo;
		if (rspValid) begin
			checkCount <= checkCount + 1;
		end
		if (readGo) begin
			expByte <= modelRead(reqAddr);
		end
		if (!rstN) begin
			dockTop = 3'd0;
		end else if (loadValid) begin
			case (loadIndex)
				tsLoadPkg::LoadHome: homeMem[loadAddr[13:0]] = loadData;
				tsLoadPkg::LoadExt: extMem[loadAddr[12:0]] = loadData;
				tsLoadPkg::LoadEsx: esxMem[loadAddr[12:0]] = loadData;
				default: begin
					dockMem[loadAddr] = loadData;
					dockTop = loadAddr[15:13];
				end
			endcase
		end else if (reqValid && reqReady && reqWrite && mapped && reqAddr[15:13] == 3'd1) begin
			// only chunk 1 under the overlay keeps a cpu write
			divMem[{page, reqAddr[12:0]}] = reqData;
		end
	end

	// ============================================================
	// assertions
	// ============================================================

	checkRspValid: assert property (@(posedge clock) disable iff (!rstN) rspValid == readPending)
	else begin
		errorCount++;
		$display("ERROR rspValid expected %h actual %h", $sampled(readPending), $sampled(rspValid));
	end

	checkRspData: assert property (@(posedge clock) disable iff (!rstN)
		rspValid |-> rspData == expByte)
	else begin
		errorCount++;
		$display("ERROR rspData expected %h actual %h", $sampled(expByte), $sampled(rspData));
	end

	// cpu held off during a loader byte and in reset
	checkLoadStall: assert property (@(posedge clock) (loadValid || !rstN) |-> !reqReady)
	else begin
		errorCount++;
		$display("ERROR reqReady expected %h actual %h", 1'b0, $sampled(reqReady));
	end

	checkResetIdle: assert property (@(posedge clock) !rstN |=> !rspValid)
	else begin
		errorCount++;
		$display("ERROR rspValid expected %h actual %h", 1'b0, $sampled(rspValid));
	end

	// run limit
	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("timeout: the tests did not finish within %0d cycles", CycleLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ============================================================
	// drivers on the falling edge
	// ============================================================

	task automatic setMap(input logic m, input logic r, input logic [3:0] p,
			input logic [7:0] mm, input logic b);
		@(negedge clock);
		reqValid = 1'b0;
		loadValid = 1'b0;
		mapped = m;
		ramcs = r;
		page = p;
		memM = mm;
		memB = b;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			reqValid = 1'b0;
			loadValid = 1'b0;
		end
	endtask

	// random image bytes one per cycle
	task automatic loadImage(input tsLoadPkg::LoadIndex idx, input int first, input int count);
		int i;
		for (i = 0; i < count; i++) begin
			@(negedge clock);
			reqValid = 1'b0;
			loadValid = 1'b1;
			loadIndex = idx;
			loadAddr = 16'(first + i);
			loadData = 8'(randomWord());
		end
		idle(1);
	endtask

	// one cpu access held until the handshake
	task automatic access(input logic write, input logic [15:0] addr, input logic [7:0] data);
		@(negedge clock);
		loadValid = 1'b0;
		reqValid = 1'b1;
		reqWrite = write;
		reqAddr = addr;
		reqData = data;
		@(posedge clock);
		while (!reqReady) @(posedge clock);
	endtask

	task automatic readChunk(input logic [2:0] chunk, input int count);
		int i;
		for (i = 0; i < count; i++) begin
			access(1'b0, {chunk, 13'(randomWord())}, 8'h00);
		end
	endtask

	task automatic reportTest(input string name);
		// let the last response through its check
		idle(2);
		testCount++;
		$display("test %0d %s finished with %0d errors", testCount, name,
			errorCount - testErrorBase);
		testErrorBase = errorCount;
	endtask

	// ============================================================
	// tests
	// ============================================================

	task automatic testHomeRom();
		int i;
		loadImage(tsLoadPkg::LoadHome, 0, 16384);
		setMap(1'b0, 1'b0, 4'd0, 8'h00, 1'b0);
		// full 16-bit addresses so mirrors are hit too
		for (i = 0; i < 512; i++) begin
			access(1'b0, 16'(randomWord()), 8'h00);
		end
		reportTest("home rom");
	endtask

	task automatic testExtRom();
		int c;
		loadImage(tsLoadPkg::LoadExt, 0, 8192);
		setMap(1'b0, 1'b0, 4'd0, 8'hFF, 1'b1);
		for (c = 0; c < 8; c++) begin
			readChunk(3'(c), 32);
		end
		// chunk 3 back to home
		setMap(1'b0, 1'b0, 4'd0, 8'hF7, 1'b1);
		readChunk(3'd3, 32);
		readChunk(3'd0, 32);
		reportTest("ext rom and open bus");
	endtask

	task automatic testDock();
		int c;
		int i;
		loadImage(tsLoadPkg::LoadDock, 0, 5 * 8192);
		setMap(1'b0, 1'b0, 4'd0, 8'hFF, 1'b0);
		for (c = 0; c < 8; c++) begin
			readChunk(3'(c), 32);
		end
		// limit moves up to chunk 6 where only the loaded bytes are read
		loadImage(tsLoadPkg::LoadDock, 16'hC000, 32);
		setMap(1'b0, 1'b0, 4'd0, 8'hFF, 1'b0);
		for (i = 0; i < 32; i++) begin
			access(1'b0, 16'(16'hC000 + i), 8'h00);
		end
		readChunk(3'd7, 32);
		reportTest("dock ram and limit");
	endtask

	task automatic testDivMmc();
		logic [3:0] pageList [4] = '{4'd0, 4'd5, 4'd10, 4'd15};
		int p;
		int i;
		loadImage(tsLoadPkg::LoadEsx, 0, 8192);
		setMap(1'b1, 1'b0, 4'd0, 8'h00, 1'b0);
		for (i = 0; i < 128; i++) begin
			access(1'b0, {2'b00, 14'(randomWord())}, 8'h00);
		end
		// overlay beats memM and memB
		setMap(1'b1, 1'b0, 4'd0, 8'hFF, 1'b1);
		readChunk(3'd0, 32);
		for (p = 0; p < 4; p++) begin
			setMap(1'b1, 1'b1, pageList[p], 8'h00, 1'b0);
			for (i = 0; i < 16; i++) begin
				access(1'b1, 16'(16'h2000 + i * 37), 8'(randomWord()));
			end
		end
		// writes that must be dropped
		setMap(1'b1, 1'b1, pageList[1], 8'h00, 1'b0);
		for (i = 0; i < 16; i++) begin
			access(1'b1, 16'(i * 37), 8'(randomWord()));
			access(1'b1, 16'(16'h4000 + i * 37), 8'(randomWord()));
		end
		setMap(1'b0, 1'b1, pageList[2], 8'h00, 1'b0);
		for (i = 0; i < 16; i++) begin
			access(1'b1, 16'(16'h2000 + i * 37), 8'(randomWord()));
		end
		// each page read back through chunk 1 and chunk 0
		for (p = 0; p < 4; p++) begin
			setMap(1'b1, 1'b1, pageList[p], 8'h00, 1'b0);
			for (i = 0; i < 16; i++) begin
				access(1'b0, 16'(16'h2000 + i * 37), 8'h00);
				access(1'b0, 16'(i * 37), 8'h00);
			end
		end
		reportTest("divmmc overlay and paging");
	endtask

	task automatic testHandshake();
		int i;
		setMap(1'b0, 1'b0, 4'd0, 8'h00, 1'b0);
		for (i = 0; i < 400; i++) begin
			@(negedge clock);
			reqValid = 1'b1;
			reqWrite = 1'b0;
			loadValid = 1'b0;
			if (i % 5 == 0) begin
				// request waits behind the loader byte at its own address
				reqAddr = 16'(randomWord());
				loadValid = 1'b1;
				loadIndex = tsLoadPkg::LoadHome;
				loadAddr = reqAddr;
				loadData = 8'(randomWord());
			end else if (i % 5 == 3) begin
				// discarded write gets no response
				reqWrite = 1'b1;
				reqAddr = 16'(randomWord());
				reqData = 8'(randomWord());
			end else if (i % 5 != 1) begin
				reqAddr = 16'(randomWord());
			end
		end
		reportTest("handshake and back-pressure");
	endtask

	initial begin
		rstN = 1'b0;
		// a read waits through reset and must not be taken
		reqValid = 1'b1;
		reqWrite = 1'b0;
		reqAddr = '0;
		reqData = '0;
		mapped = 1'b0;
		ramcs = 1'b0;
		page = '0;
		memM = '0;
		memB = 1'b0;
		loadValid = 1'b0;
		loadIndex = tsLoadPkg::LoadHome;
		loadAddr = '0;
		loadData = '0;
		repeat (8) @(negedge clock);
		reqValid = 1'b0;
		rstN = 1'b1;
		testHomeRom();
		testExtRom();
		testDock();
		testDivMmc();
		testHandshake();
		$display("summary: %0d tests, %0d responses checked, %0d errors", testCount, checkCount,
			errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/tsMemMap.sv */
// memory map top level with decoder, byte banks and read selector
`timescale 1ns/1ps
`default_nettype none

module tsMemMap (
	input wire clock,
	input wire rstN,
	// cpu request
	input wire reqValid,
	output logic reqReady,
	input wire reqWrite,
	input wire [tsMemPkg::CpuAddrWidth-1:0] reqAddr,
	input wire [tsMemPkg::ByteWidth-1:0] reqData,
	// map controls from the cpu core
	input wire mapped,
	input wire ramcs,
	input wire [tsMemPkg::PageWidth-1:0] page,
	input wire [tsMemPkg::ChunkCount-1:0] memM,
	input wire memB,
	// read response
	output logic rspValid,
	output logic [tsMemPkg::ByteWidth-1:0] rspData,
	// image loader
	input wire loadValid,
	input wire tsLoadPkg::LoadIndex loadIndex,
	input wire [tsLoadPkg::LoadAddrWidth-1:0] loadAddr,
	input wire [tsMemPkg::ByteWidth-1:0] loadData
);

	// widest bank address, divmmc ram
	localparam int AddrMax = tsMemPkg::MaxBankAddrWidth;

	logic [tsMemPkg::BankCount-1:0][AddrMax-1:0] bankAddr;
	logic [tsMemPkg::BankCount-1:0] bankWrite;
	logic [tsMemPkg::ByteWidth-1:0] bankData;
	logic [tsMemPkg::BankCount-1:0][tsMemPkg::ByteWidth-1:0] bankQ;
	logic rdAccept;
	tsMemPkg::ReadSel rdSel;

	// ============================================================
	// decode
	// ============================================================

	mapDecoder #(
		.AddrMax(AddrMax)
	) decoder (
		.clock(clock),
		.rstN(rstN),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.mapped(mapped),
		.ramcs(ramcs),
		.page(page),
		.memM(memM),
		.memB(memB),
		.loadValid(loadValid),
		.loadIndex(loadIndex),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.bankAddr(bankAddr),
		.bankWrite(bankWrite),
		.bankData(bankData),
		.rdAccept(rdAccept),
		.rdSel(rdSel)
	);

	// ============================================================
	// stores
	// ============================================================

	// one bank per BankId, each sized from the table
	for (genvar b = int'(tsMemPkg::BankHome); b <= int'(tsMemPkg::BankDivRam); b++) begin
		: genBank
		byteBank #(
			.AddrWidth(tsMemPkg::BankAddrWidth[b])
		) bank (
			.clock(clock),
			.addr(bankAddr[b][tsMemPkg::BankAddrWidth[b]-1:0]),
			.data(bankData),
			.write(bankWrite[b]),
			.q(bankQ[b])
		);
	end

	// ============================================================
	// response
	// ============================================================

	readSelect #(
		.Banks(tsMemPkg::BankCount)
	) selector (
		.clock(clock),
		.rstN(rstN),
		.rdAccept(rdAccept),
		.rdSel(rdSel),
		.bankQ(bankQ),
		.rspValid(rspValid),
		.rspData(rspData)
	);

endmodule

`default_nettype wire

/* rtl/readSelect.sv */
// response valid tracking and read data steering with open bus
`timescale 1ns/1ps
`default_nettype none

module readSelect #(
	parameter int Banks = 5
) (
	input wire clock,
	input wire rstN,
	// from the decoder, in the accept cycle
	input wire rdAccept,
	input wire tsMemPkg::ReadSel rdSel,
	// registered bank outputs
	input wire [Banks-1:0][tsMemPkg::ByteWidth-1:0] bankQ,
	// response
	output logic rspValid,
	output logic [tsMemPkg::ByteWidth-1:0] rspData
);

	tsMemPkg::ReadSel selQ;

	// ============================================================
	// response timing
	// ============================================================

	// one cycle, same as the bank read latency
	always_ff @(posedge clock) begin
		if (!rstN) begin
			rspValid <= 1'b0;
		end else begin
			rspValid <= rdAccept;
		end
	end

	// selection follows its data through the bank register
	always_ff @(posedge clock) begin
		selQ <= rdSel;
	end

	// ============================================================
	// data steering
	// ============================================================

	always_comb begin
		if (selQ == tsMemPkg::SelOpenBus || int'(selQ) >= Banks) begin
			// nothing decoded there
			rspData = tsMemPkg::OpenBusByte;
		end else begin
			rspData = bankQ[selQ];
		end
	end

endmodule

`default_nettype wire

/* rtl/mapDecoder.sv */
// request handshake, bank selection, bank addresses, write strobes and dock limit
`timescale 1ns/1ps
`default_nettype none

module mapDecoder #(
	parameter int AddrMax = 17
) (
	input wire clock,
	input wire rstN,
	// cpu request
	input wire reqValid,
	output logic reqReady,
	input wire reqWrite,
	input wire [tsMemPkg::CpuAddrWidth-1:0] reqAddr,
	input wire [tsMemPkg::ByteWidth-1:0] reqData,
	// map controls, sampled with the request
	input wire mapped,
	input wire ramcs,
	input wire [tsMemPkg::PageWidth-1:0] page,
	input wire [tsMemPkg::ChunkCount-1:0] memM,
	input wire memB,
	// loader
	input wire loadValid,
	input wire tsLoadPkg::LoadIndex loadIndex,
	input wire [tsLoadPkg::LoadAddrWidth-1:0] loadAddr,
	input wire [tsMemPkg::ByteWidth-1:0] loadData,
	// to the banks
	output logic [tsMemPkg::BankCount-1:0][AddrMax-1:0] bankAddr,
	output logic [tsMemPkg::BankCount-1:0] bankWrite,
	output logic [tsMemPkg::ByteWidth-1:0] bankData,
	// to the read selector
	output logic rdAccept,
	output tsMemPkg::ReadSel rdSel
);

	logic accept;
	logic [tsMemPkg::ChunkWidth-1:0] chunk;
	logic [tsMemPkg::ChunkWidth-1:0] dockTop;
	logic [AddrMax-1:0] cpuWideAddr;
	logic [AddrMax-1:0] divWideAddr;
	logic [AddrMax-1:0] loadWideAddr;
	tsMemPkg::BankId loadBank;

	// image code to store
	function automatic tsMemPkg::BankId loadTarget(input tsLoadPkg::LoadIndex idx);
		case (idx)
			tsLoadPkg::LoadHome: loadTarget = tsMemPkg::BankHome;
			tsLoadPkg::LoadExt: loadTarget = tsMemPkg::BankExt;
			tsLoadPkg::LoadEsx: loadTarget = tsMemPkg::BankEsx;
			default: loadTarget = tsMemPkg::BankDock;
		endcase
	endfunction

	// ============================================================
	// handshake
	// ============================================================

	// loader owns the banks, cpu waits
	assign reqReady = rstN && !loadValid;
	assign accept = reqValid && reqReady;
	assign rdAccept = accept && !reqWrite;

	assign chunk = reqAddr[tsMemPkg::CpuAddrWidth-1 -: tsMemPkg::ChunkWidth];
	assign loadBank = loadTarget(loadIndex);

	// ============================================================
	// dock size limit
	// ============================================================

	// last dock byte loaded sets the highest decoded chunk
	always_ff @(posedge clock) begin
		if (!rstN) begin
			dockTop <= '0;
		end else if (loadValid && loadIndex == tsLoadPkg::LoadDock) begin
			dockTop <= loadAddr[tsLoadPkg::LoadAddrWidth-1 -: tsMemPkg::ChunkWidth];
		end
	end

	// ============================================================
	// read selection
	// ============================================================

	always_comb begin
		if (mapped && chunk <= tsMemPkg::OverlayTopChunk) begin
			// divmmc overlay on the lower 16K
			rdSel = ramcs ? tsMemPkg::SelDivRam : tsMemPkg::SelEsx;
		end else if (memM[chunk]) begin
			if (memB) begin
				// ext rom only answers in chunk 0
				rdSel = (chunk == tsMemPkg::ExtChunk) ? tsMemPkg::SelExt
					: tsMemPkg::SelOpenBus;
			end else begin
				// dock decoded up to the loaded size
				rdSel = (chunk <= dockTop) ? tsMemPkg::SelDock : tsMemPkg::SelOpenBus;
			end
		end else begin
			rdSel = tsMemPkg::SelHome;
		end
	end

	// ============================================================
	// bank addresses and data
	// ============================================================

	// narrower banks take the low bits only
	assign cpuWideAddr = AddrMax'(reqAddr);
	assign divWideAddr = AddrMax'({page, reqAddr[tsMemPkg::ChunkOffsetWidth-1:0]});
	assign loadWideAddr = AddrMax'(loadAddr);

	always_comb begin
		for (int b = 0; b < tsMemPkg::BankCount; b++) begin
			if (loadValid) begin
				bankAddr[b] = loadWideAddr;
			end else if (b == int'(tsMemPkg::BankDivRam)) begin
				// page above the chunk offset
				bankAddr[b] = divWideAddr;
			end else begin
				bankAddr[b] = cpuWideAddr;
			end
		end
	end

	assign bankData = loadValid ? loadData : reqData;

	// write strobes, loader first
	always_comb begin
		bankWrite = '0;
		if (loadValid) begin
			bankWrite[loadBank] = 1'b1;
		end else if (accept && reqWrite && mapped && chunk == tsMemPkg::DivRamChunk) begin
			// only divmmc ram in chunk 1 is writable by the cpu
			bankWrite[tsMemPkg::BankDivRam] = 1'b1;
		end
		// any other cpu write is dropped
	end

endmodule

`default_nettype wire

/* rtl/byteBank.sv */
// single-port byte store with synchronous read
`timescale 1ns/1ps
`default_nettype none

module byteBank #(
	parameter int AddrWidth = 13
) (
	input wire clock,
	input wire [AddrWidth-1:0] addr,
	input wire [tsMemPkg::ByteWidth-1:0] data,
	input wire write,
	output logic [tsMemPkg::ByteWidth-1:0] q
);

	// 2^AddrWidth bytes
	logic [tsMemPkg::ByteWidth-1:0] mem [2 ** AddrWidth];

	// ============================================================
	// store port
	// ============================================================

	always_ff @(posedge clock) begin
		if (write) begin
			mem[addr] <= data;
		end
		// read every cycle, old data on a same-address write
		q <= mem[addr];
	end

endmodule

`default_nettype wire

/* rtl/tsLoadPkg.sv */
// loader image index codes and loader address width
`default_nettype none

package tsLoadPkg;

	// loader address, wide enough for the dock image
	localparam int LoadAddrWidth = 16;

	// which image the loader byte belongs to
	typedef enum logic [1:0] {
		LoadHome = 2'd0,
		LoadExt = 2'd1,
		LoadEsx = 2'd2,
		LoadDock = 2'd3
	} LoadIndex;

	// divmmc ram has no image, it is filled by the cpu only

endpackage

`default_nettype wire

/* rtl/tsMemPkg.sv */
// memory-map widths, bank identifiers, bank address widths and chunk constants
`default_nettype none

package tsMemPkg;

	// ============================================================
	// cpu side
	// ============================================================

	localparam int CpuAddrWidth = 16;
	localparam int ByteWidth = 8;
	// 8 KB chunks, eight of them in the cpu space
	localparam int ChunkWidth = 3;
	localparam int ChunkCount = 2 ** ChunkWidth;
	localparam int ChunkOffsetWidth = CpuAddrWidth - ChunkWidth;
	// divmmc ram page select
	localparam int PageWidth = 4;

	// chunk numbers with a fixed role
	localparam logic [ChunkWidth-1:0] ExtChunk = 3'd0;
	localparam logic [ChunkWidth-1:0] DivRamChunk = 3'd1;
	// divmmc overlay covers chunks 0 and 1
	localparam logic [ChunkWidth-1:0] OverlayTopChunk = 3'd1;

	// ============================================================
	// stores
	// ============================================================

	localparam int BankCount = 5;

	// doubles as the generate index of the banks
	typedef enum logic [2:0] {
		BankHome = 3'd0,
		BankExt = 3'd1,
		BankDock = 3'd2,
		BankEsx = 3'd3,
		BankDivRam = 3'd4
	} BankId;

	// 16K, 8K, 64K, 8K, 128K
	localparam int BankAddrWidth [BankCount] = '{14, 13, 16, 13, 17};
	localparam int MaxBankAddrWidth = 17;

	// same order as BankId, plus the unmapped case
	typedef enum logic [2:0] {
		SelHome = 3'd0,
		SelExt = 3'd1,
		SelDock = 3'd2,
		SelEsx = 3'd3,
		SelDivRam = 3'd4,
		SelOpenBus = 3'd5
	} ReadSel;

	// floating data bus reads as all ones
	localparam logic [ByteWidth-1:0] OpenBusByte = 8'hFF;

endpackage

`default_nettype wire
